/* Bender.yml */
package:
  name: ps2_key_display

sources:
  - hw/ps2_pkg.sv
  - hw/display_pkg.sv
  - hw/ps2_if.sv
  - hw/ps2_receiver.sv
  - hw/key_tracker.sv
  - hw/seg7_decoder.sv
  - hw/ps2_key_display.sv
  - target: test
    files:
      - test/ps2_key_display_checker.sv
      - test/ps2_key_display_tb.sv

/* hw/display_pkg.sv */
`default_nettype none

package display_pkg;

    // one hex digit.
    typedef logic [3:0] nibble_t;

    // segments a..g in bits 0..6, decimal point in bit 7.
    // all active low.
    typedef logic [7:0] seg_t;

    localparam seg_t seg_blank = 8'hFF; // every segment dark.

endpackage

`default_nettype wire

/* hw/key_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module key_tracker
(
    input wire                  clk,
    input wire                  rst,
    ps2_if.tracker              bus,
    output ps2_pkg::scan_code_t key_value,
    output logic                blank
);

    ps2_pkg::tracker_state_t state;
    ps2_pkg::tracker_state_t state_next;
    ps2_pkg::scan_code_t     code_q;

    always_ff @(posedge clk)
    begin
        if (!rst)
            state <= ps2_pkg::idle;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            ps2_pkg::idle:
            begin
                if (bus.ready)
                    state_next = ps2_pkg::fetch;
            end
            ps2_pkg::fetch:
            begin
                if (bus.code == ps2_pkg::break_code)
                    state_next = ps2_pkg::break_wait;
                else
                    state_next = ps2_pkg::make_wait;
            end
            ps2_pkg::make_wait:
            begin
                state_next = ps2_pkg::idle;
            end
            ps2_pkg::break_wait:
            begin
                state_next = ps2_pkg::break_fetch;
            end
            ps2_pkg::break_fetch:
            begin
                if (bus.ready)
                    state_next = ps2_pkg::release_wait; // released code popped here.
            end
            ps2_pkg::release_wait:
            begin
                state_next = ps2_pkg::idle;
            end
            default:
            begin
                state_next = ps2_pkg::idle;
            end
        endcase
    end

    // one pop per fetch state.
    assign bus.next_n = !((state == ps2_pkg::fetch)
                          || (state == ps2_pkg::break_fetch && bus.ready));

    // head changes after the pop, so keep a copy.
    always_ff @(posedge clk)
    begin
        if (state == ps2_pkg::fetch)
            code_q <= bus.code;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            key_value <= '0;
            blank     <= 1'b1; // dark until the first make.
        end
        else if (state == ps2_pkg::make_wait)
        begin
            key_value <= code_q;
            blank     <= 1'b0;
        end
        else if (state == ps2_pkg::break_wait)
        begin
            blank <= 1'b1; // key_value kept.
        end
    end

endmodule

`default_nettype wire

/* hw/ps2_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ps2_if;

    ps2_pkg::scan_code_t code; // head of the receive queue.
    logic                ready; // queue holds at least one code.
    logic                clrn; // active-low queue clear.
    logic                next_n; // active-low pop strobe.

    modport receiver
    (
        output code,
        output ready,
        input  clrn,
        input  next_n
    );

    modport tracker
    (
        input  code,
        input  ready,
        output next_n
    );

endinterface

`default_nettype wire

/* hw/ps2_key_display.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_key_display
(
    input wire                clk,
    input wire                rst,
    input wire                ps2_clk,
    input wire                ps2_dat,
    output display_pkg::seg_t seg_low,
    output display_pkg::seg_t seg_high
);

    ps2_pkg::scan_code_t  key_value;
    logic                 blank;
    display_pkg::nibble_t digit_low;
    display_pkg::nibble_t digit_high;

    ps2_if bus ();

    assign bus.clrn = rst; // queue clear follows reset only.

    ps2_receiver u_receiver
    (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .bus     (bus.receiver)
    );

    key_tracker u_tracker
    (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus.tracker),
        .key_value (key_value),
        .blank     (blank)
    );

    assign digit_low  = key_value[3:0];
    assign digit_high = key_value[7:4];

    seg7_decoder u_seg_low  (.digit(digit_low),  .blank(blank), .seg(seg_low));
    seg7_decoder u_seg_high (.digit(digit_high), .blank(blank), .seg(seg_high));

endmodule

`default_nettype wire

/* hw/ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

    // one keyboard scan code.
    typedef logic [7:0] scan_code_t;

    localparam scan_code_t break_code = 8'hF0; // prefix sent before a released key.

    localparam int unsigned frame_bits = 11; // start, 8 data, parity, stop.
    localparam int unsigned frame_cnt_bits = $clog2(frame_bits);
    typedef logic [frame_cnt_bits-1:0] bit_cnt_t;

    localparam int unsigned fifo_depth = 8; // power of two, pointers wrap on their own.
    localparam int unsigned fifo_ptr_bits = $clog2(fifo_depth);
    typedef logic [fifo_ptr_bits-1:0] fifo_ptr_t;
    typedef logic [fifo_ptr_bits:0] fifo_count_t;

    typedef enum logic [2:0] {
        idle,
        fetch,
        make_wait,
        break_wait,
        break_fetch,
        release_wait
    } tracker_state_t;

endpackage

`default_nettype wire

/* hw/ps2_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver
(
    input wire      clk,
    input wire      rst,
    input wire      ps2_clk,
    input wire      ps2_dat,
    ps2_if.receiver bus
);

    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       clk_fall;

    ps2_pkg::bit_cnt_t                 bit_cnt;
    logic [ps2_pkg::frame_bits-1:0]    frame;
    logic                              frame_done;
    logic                              frame_ok;

    ps2_pkg::scan_code_t               mem [ps2_pkg::fifo_depth];
    ps2_pkg::fifo_ptr_t                wr_ptr;
    ps2_pkg::fifo_ptr_t                rd_ptr;
    ps2_pkg::fifo_count_t              count;
    logic                              fifo_clear;
    logic                              full;
    logic                              wr_en;
    logic                              rd_en;

    // two-flop synchronizers, plus one more stage for edge detection.
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev && !clk_sync[1];

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (clk_fall)
            begin
                if (bit_cnt == ps2_pkg::bit_cnt_t'(ps2_pkg::frame_bits - 1))
                begin
                    bit_cnt    <= '0;
                    frame_done <= 1'b1; // check and write on the next clock.
                end
                else if (bit_cnt != '0 || !dat_sync[1])
                begin
                    bit_cnt <= bit_cnt + 1'b1; // a high start bit is not a frame.
                end
            end
        end
    end

    // lsb first, so the start bit ends up in bit 0.
    always_ff @(posedge clk)
    begin
        if (clk_fall)
            frame <= {dat_sync[1], frame[ps2_pkg::frame_bits-1:1]};
    end

    // low start, high stop, odd parity over data and parity bit.
    assign frame_ok = !frame[0] && frame[ps2_pkg::frame_bits-1]
                      && (^frame[ps2_pkg::frame_bits-2:1]);

    assign fifo_clear = !rst || !bus.clrn;
    assign full       = (count == ps2_pkg::fifo_count_t'(ps2_pkg::fifo_depth));
    assign wr_en      = frame_done && frame_ok && !full; // frame is lost when full.
    assign rd_en      = !bus.next_n && bus.ready;

    always_ff @(posedge clk)
    begin
        if (fifo_clear)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= frame[ps2_pkg::frame_bits-3:1];
    end

    assign bus.code  = mem[rd_ptr];
    assign bus.ready = (count != '0);

endmodule

`default_nettype wire

/* hw/seg7_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module seg7_decoder
(
    input wire display_pkg::nibble_t digit,
    input wire                       blank,
    output display_pkg::seg_t        seg
);

    // active low, decimal point held off in bit 7.
    always_comb
    begin
        seg = display_pkg::seg_blank;
        if (!blank)
        begin
            case (digit)
                4'h0: seg = 8'hC0;
                4'h1: seg = 8'hF9;
                4'h2: seg = 8'hA4;
                4'h3: seg = 8'hB0;
                4'h4: seg = 8'h99;
                4'h5: seg = 8'h92;
                4'h6: seg = 8'h82;
                4'h7: seg = 8'hF8;
                4'h8: seg = 8'h80;
                4'h9: seg = 8'h90;
                4'hA: seg = 8'h88;
                4'hB: seg = 8'h83; // lower case b.
                4'hC: seg = 8'hC6;
                4'hD: seg = 8'hA1; // lower case d.
                4'hE: seg = 8'h86;
                4'hF: seg = 8'h8E;
                default: seg = display_pkg::seg_blank;
            endcase
        end
    end

endmodule

`default_nettype wire

/* ps2_key_display.f */
hw/ps2_pkg.sv
hw/display_pkg.sv
hw/ps2_if.sv
hw/ps2_receiver.sv
hw/key_tracker.sv
hw/seg7_decoder.sv
hw/ps2_key_display.sv
test/ps2_key_display_checker.sv
test/ps2_key_display_tb.sv

/* test/ps2_key_display_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_key_display_checker
(
    input wire                         clk,
    input wire                         rst,
    input wire                         next_n,
    input wire                         ready,
    input wire                         blank,
    input var ps2_pkg::tracker_state_t state
);

    int unsigned failures = 0;

    pop_single_cycle: assert property (@(posedge clk) disable iff (!rst)
        !next_n |=> next_n)
    else
    begin
        failures++;
        $error("pop strobe held low for more than one cycle");
    end

    pop_needs_ready: assert property (@(posedge clk) disable iff (!rst)
        !next_n |-> ready)
    else
    begin
        failures++;
        $error("pop strobe low while the queue is empty");
    end

    // blank rises at the end of break_wait and stays up until the next make.
    break_blanks: assert property (@(posedge clk) disable iff (!rst)
        state inside {ps2_pkg::break_fetch, ps2_pkg::release_wait} |-> blank)
    else
    begin
        failures++;
        $error("display not blank during a break sequence");
    end

endmodule

`default_nettype wire

/* test/ps2_key_display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_key_display_tb;

    typedef struct packed
    {
        display_pkg::seg_t high;
        display_pkg::seg_t low;
    } seg_pair_t;

    localparam int half_period = 10; // ps2 clock half period in system clocks.

    // active low, a..g in bits 0..6.
    localparam display_pkg::seg_t seg_table [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
    };

    logic                clk;
    logic                rst;
    logic                ps2_clk;
    logic                ps2_dat;
    display_pkg::seg_t   seg_low;
    display_pkg::seg_t   seg_high;

    logic [15:0]         lfsr = 16'd80;
    logic                ref_blank = 1'b1;
    logic                ref_break = 1'b0;
    ps2_pkg::scan_code_t ref_value = '0;
    seg_pair_t           last_pair;
    seg_pair_t           exp_q[$];
    string               name_q[$];
    int                  checks = 0;
    int                  errors = 0;

    ps2_key_display dut0
    (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .seg_low  (seg_low),
        .seg_high (seg_high)
    );

    bind key_tracker ps2_key_display_checker u_checker
    (
        .clk    (clk),
        .rst    (rst),
        .next_n (bus.next_n),
        .ready  (bus.ready),
        .blank  (blank),
        .state  (state)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected display after one more scan code.
    function automatic seg_pair_t expect_after(ps2_pkg::scan_code_t code);
        if (ref_break)
            ref_break = 1'b0; // released key, display stays dark.
        else if (code == 8'hF0)
        begin
            ref_break = 1'b1;
            ref_blank = 1'b1;
        end
        else
        begin
            ref_value = code;
            ref_blank = 1'b0;
        end
        if (ref_blank)
            return '{8'hFF, 8'hFF};
        return '{seg_table[ref_value[7:4]], seg_table[ref_value[3:0]]};
    endfunction

    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out)
            lfsr = lfsr ^ 16'hB400;
        return out;
    endfunction

    function automatic ps2_pkg::scan_code_t random_code();
        ps2_pkg::scan_code_t code;
        for (int i = 0; i < 8; i++)
            code[i] = lfsr_bit();
        return (code == 8'hF0) ? 8'h00 : code; // keep it a make code.
    endfunction

    task automatic send_frame(ps2_pkg::scan_code_t code, logic bad_parity);
        logic [ps2_pkg::frame_bits-1:0] bits;
        bits = {1'b1, ~^code ^ bad_parity, code, 1'b0};
        for (int i = 0; i < ps2_pkg::frame_bits; i++)
        begin
            @(posedge clk);
            ps2_dat <= bits[i]; // data settles while ps2_clk is high.
            repeat (half_period / 2) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (half_period) @(posedge clk);
            ps2_clk <= 1'b1;
            repeat (half_period / 2 - 1) @(posedge clk);
        end
        @(posedge clk);
        ps2_dat <= 1'b1;
    endtask

    task automatic check_seg(string test_name, display_pkg::seg_t expected,
                             display_pkg::seg_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    task automatic expect_display(string test_name, seg_pair_t pair);
        int waited;
        last_pair = pair;
        exp_q.push_back(pair);
        name_q.push_back(test_name);
        waited = 0;
        while (name_q.size() != 0 && waited < 64)
        begin
            @(posedge clk);
            waited++;
        end
        if (name_q.size() != 0)
        begin
            errors++;
            $display("timeout: display check for %s did not complete", test_name);
        end
    endtask

    // compares on the falling edge, away from register updates.
    initial
    begin : compare
        seg_pair_t want;
        int        waited;
        forever
        begin
            @(negedge clk);
            if (exp_q.size() != 0)
            begin
                want   = exp_q[0];
                waited = 0;
                while ({seg_high, seg_low} !== want && waited < 16)
                begin
                    @(negedge clk);
                    waited++;
                end
                check_seg({name_q[0], " high"}, want.high, seg_high);
                check_seg({name_q[0], " low"}, want.low, seg_low);
                void'(exp_q.pop_front());
                void'(name_q.pop_front());
            end
        end
    end

    initial
    begin : stimulus
        ps2_pkg::scan_code_t code;
        rst     = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        expect_display("reset", '{8'hFF, 8'hFF});
        send_frame(8'h1C, 1'b0);
        expect_display("make_1c", expect_after(8'h1C));
        send_frame(8'hF0, 1'b0);
        expect_display("break_prefix", expect_after(8'hF0));
        send_frame(8'h1C, 1'b0);
        expect_display("break_release", expect_after(8'h1C));
        send_frame(8'h32, 1'b0);
        expect_display("make_after_break", expect_after(8'h32));
        send_frame(8'h45, 1'b1);
        expect_display("bad_parity", last_pair); // frame dropped.
        for (int i = 0; i < 20; i++)
        begin
            code = random_code();
            send_frame(code, 1'b0);
            expect_display($sformatf("random_%0d", i), expect_after(code));
            repeat (half_period) @(posedge clk);
        end
        send_frame(8'h11, 1'b0);
        void'(expect_after(8'h11));
        send_frame(8'h22, 1'b0);
        void'(expect_after(8'h22));
        send_frame(8'h3A, 1'b0);
        expect_display("back_to_back", expect_after(8'h3A));
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.u_tracker.u_checker.failures);
        if (errors == 0 && dut0.u_tracker.u_checker.failures == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
